// File: common/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W = DATA_W / 8;

    // Load/store unit request, one per strobe
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [BE_W-1:0] be;
        logic [DATA_W-1:0] data;
        logic uncacheable;
    } ls_req_t;

    // Shared L1 bus request, held stable until ack
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [BE_W-1:0] be;
        logic rnw;
        logic [4:0] burst_len;
    } l1_req_t;

    typedef struct packed {
        logic data_valid;
        logic [DATA_W-1:0] data;
    } l1_resp_t;

    // Line index above the word-in-line field
    function automatic logic [ADDR_W-1:0] line_index(input logic [ADDR_W-1:0] addr,
                                                     input int lines, input int line_w);
        return (addr >> (2 + $clog2(line_w))) & ADDR_W'(lines - 1);
    endfunction

    // Word offset within a cache line
    function automatic logic [ADDR_W-1:0] word_in_line(input logic [ADDR_W-1:0] addr,
                                                       input int line_w);
        return (addr >> 2) & ADDR_W'(line_w - 1);
    endfunction

endpackage

`default_nettype wire

// File: dcache/dcache_data_bank.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_data_bank #(
    parameter int AW = 8
) (
    input logic clk,
    input logic [AW-1:0] addr_a,
    input logic en_a,
    input logic we_a,
    input logic [dcache_pkg::DATA_W-1:0] data_in_a,
    output logic [dcache_pkg::DATA_W-1:0] data_out_a,
    input logic [AW-1:0] addr_b,
    input logic en_b,
    input logic [dcache_pkg::BE_W-1:0] be_b,
    input logic [dcache_pkg::DATA_W-1:0] data_in_b
);

    logic [dcache_pkg::BE_W-1:0][7:0] mem [2**AW];

    always_ff @(posedge clk) begin
        // Port A, write-first so a fill word is visible on the output
        if (en_a) begin
            if (we_a) begin
                mem[addr_a] <= data_in_a;
                data_out_a <= data_in_a;
            end else begin
                data_out_a <= mem[addr_a];
            end
        end
        // Port B, store hits merge by byte
        if (en_b) begin
            for (int i = 0; i < dcache_pkg::BE_W; i++) begin
                if (be_b[i]) begin
                    mem[addr_b][i] <= data_in_b[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dcache/dcache_tag_bank.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_bank #(
    parameter int WAYS = 2,
    parameter int LINES = 64,
    parameter int LINE_W = 4
) (
    input logic clk,
    input logic rst,
    input logic [dcache_pkg::ADDR_W-1:0] load_addr,
    input logic load_check,
    input logic [dcache_pkg::ADDR_W-1:0] fill_addr,
    input logic fill_req,
    input logic [WAYS-1:0] fill_way,
    input logic [dcache_pkg::ADDR_W-1:0] store_addr,
    input logic [dcache_pkg::ADDR_W-1:0] store_addr_r,
    input logic store_check,
    output logic load_hit,
    output logic [WAYS-1:0] load_hit_way,
    output logic [WAYS-1:0] store_hit_way
);

    localparam int LINE_IDX_W = $clog2(LINES);
    localparam int TAG_W = dcache_pkg::ADDR_W - 2 - $clog2(LINE_W) - LINE_IDX_W;

    logic [TAG_W-1:0] tags [WAYS][LINES];
    logic [WAYS-1:0][LINES-1:0] valid;

    logic [LINE_IDX_W-1:0] load_idx;
    logic [LINE_IDX_W-1:0] store_idx;
    logic [LINE_IDX_W-1:0] fill_idx;
    logic [TAG_W-1:0] fill_tag;
    logic [TAG_W-1:0] store_tag;

    logic [TAG_W-1:0] load_tag_r [WAYS];
    logic [TAG_W-1:0] store_tag_r [WAYS];
    logic [WAYS-1:0] load_valid_r;
    logic [WAYS-1:0] store_valid_r;
    logic load_check_r;
    logic store_check_r;

    assign load_idx = LINE_IDX_W'(dcache_pkg::line_index(load_addr, LINES, LINE_W));
    assign store_idx = LINE_IDX_W'(dcache_pkg::line_index(store_addr, LINES, LINE_W));
    assign fill_idx = LINE_IDX_W'(dcache_pkg::line_index(fill_addr, LINES, LINE_W));

    // Stage-2 load address doubles as the compare tag and the fill tag
    assign fill_tag = fill_addr[dcache_pkg::ADDR_W-1 -: TAG_W];
    assign store_tag = store_addr_r[dcache_pkg::ADDR_W-1 -: TAG_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            load_check_r <= 1'b0;
            store_check_r <= 1'b0;
        end else begin
            load_check_r <= load_check;
            store_check_r <= store_check;
            for (int w = 0; w < WAYS; w++) begin
                if (fill_req && fill_way[w]) begin
                    valid[w][fill_idx] <= 1'b1;
                end
            end
        end
    end

    // Tag write on fill, tag read on the request cycle
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (fill_req && fill_way[w]) begin
                tags[w][fill_idx] <= fill_tag;
            end
            if (load_check) begin
                load_tag_r[w] <= tags[w][load_idx];
                load_valid_r[w] <= valid[w][load_idx];
            end
            if (store_check) begin
                store_tag_r[w] <= tags[w][store_idx];
                store_valid_r[w] <= valid[w][store_idx];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            load_hit_way[w] = load_check_r & load_valid_r[w] & (load_tag_r[w] == fill_tag);
            store_hit_way[w] = store_check_r & store_valid_r[w] & (store_tag_r[w] == store_tag);
        end
    end

    assign load_hit = |load_hit_way;

endmodule

`default_nettype wire

// File: dcache/dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache #(
    parameter int WAYS = 2,
    parameter int LINES = 64,
    parameter int LINE_W = 4
) (
    input logic clk,
    input logic rst,
    input logic load_request,
    input dcache_pkg::ls_req_t load_req,
    input logic store_request,
    input dcache_pkg::ls_req_t store_req,
    output logic load_ready,
    output logic store_ready,
    output logic load_hit,
    output logic data_valid,
    output logic [dcache_pkg::DATA_W-1:0] data_out,
    input logic arb_load_sel,
    output logic l1_request,
    output dcache_pkg::l1_req_t l1_req,
    input logic l1_ack,
    input dcache_pkg::l1_resp_t l1_resp
);

    localparam int WAY_IDX_W = (WAYS > 1) ? $clog2(WAYS) : 1;
    localparam int LINE_IDX_W = $clog2(LINES);
    localparam int WORD_W = $clog2(LINE_W);
    localparam int BANK_AW = LINE_IDX_W + WORD_W;
    localparam logic [WORD_W-1:0] END_WORD = WORD_W'(LINE_W - 1);

    // One-hot state bit positions
    localparam int LD_IDLE = 0;
    localparam int LD_CHECK = 1;
    localparam int LD_REQ = 2;
    localparam int LD_FILL = 3;
    localparam int ST_IDLE = 0;
    localparam int ST_REQ = 1;

    typedef struct packed {
        logic [dcache_pkg::ADDR_W-1:0] addr;
        logic uncacheable;
    } load_stage2_t;

    load_stage2_t stage2_load;
    dcache_pkg::ls_req_t stage2_store;

    logic [3:0] load_state, load_next;
    logic [1:0] store_state, store_next;

    logic load_tag_check;
    logic load_ack;
    logic store_ack;
    logic [WAYS-1:0] load_hit_way;
    logic [WAYS-1:0] store_hit_way;

    logic [WAYS-1:0] repl_way;
    logic [WAYS-1:0] fill_way_r;
    logic [WAY_IDX_W-1:0] fill_idx;
    logic [WAY_IDX_W-1:0] hit_idx;
    logic [WAYS-1:0] fill_we;

    logic [WORD_W-1:0] word_count;
    logic is_target_word;
    logic line_complete;
    logic miss_capture;
    logic miss_valid_r;
    logic [dcache_pkg::DATA_W-1:0] uc_word;

    logic [BANK_AW-1:0] bank_addr_a;
    logic [BANK_AW-1:0] bank_addr_b;
    logic [dcache_pkg::DATA_W-1:0] bank_out [WAYS];

    function automatic logic [WAY_IDX_W-1:0] onehot_to_idx(input logic [WAYS-1:0] onehot);
        logic [WAY_IDX_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < WAYS; i++) begin
            if (onehot[i]) begin
                idx = idx | WAY_IDX_W'(i);
            end
        end
        return idx;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Load path
    always_ff @(posedge clk) begin
        if (rst) begin
            load_state <= 4'b0001;
        end else begin
            load_state <= load_next;
        end
    end

    always_comb begin
        load_next[LD_IDLE] = (load_state[LD_IDLE] & ~load_request)
                           | (load_hit & ~load_request) | line_complete;
        load_next[LD_CHECK] = load_request;
        load_next[LD_REQ] = (load_state[LD_REQ] & ~load_ack)
                          | (load_state[LD_CHECK] & ~load_hit);
        load_next[LD_FILL] = (load_state[LD_FILL] & ~line_complete)
                           | (load_state[LD_REQ] & load_ack);
    end

    assign load_ready = (load_state[LD_IDLE] | load_hit) & store_state[ST_IDLE];
    assign load_tag_check = load_request & ~load_req.uncacheable;

    always_ff @(posedge clk) begin
        if (load_request) begin
            stage2_load.addr <= load_req.addr;
            stage2_load.uncacheable <= load_req.uncacheable;
        end
    end

    // Miss word counter, follows the ascending burst
    always_ff @(posedge clk) begin
        if (rst || load_request) begin
            word_count <= '0;
        end else if (l1_resp.data_valid) begin
            word_count <= word_count + WORD_W'(1);
        end
    end

    assign is_target_word = (WORD_W'(dcache_pkg::word_in_line(stage2_load.addr, LINE_W))
                             == word_count) | stage2_load.uncacheable;
    assign line_complete = load_state[LD_FILL] & l1_resp.data_valid
                         & ((word_count == END_WORD) | stage2_load.uncacheable);
    assign miss_capture = load_state[LD_FILL] & l1_resp.data_valid & is_target_word;

    ////////////////////////////////////////////////////////////////////////////
    // Store path
    always_ff @(posedge clk) begin
        if (rst) begin
            store_state <= 2'b01;
        end else begin
            store_state <= store_next;
        end
    end

    always_comb begin
        store_next[ST_IDLE] = (store_state[ST_IDLE] & ~store_request)
                            | (store_ack & ~store_request);
        store_next[ST_REQ] = (store_state[ST_REQ] & ~store_ack) | store_request;
    end

    assign store_ready = (store_state[ST_IDLE] | store_ack) & (load_state[LD_IDLE] | load_hit);

    always_ff @(posedge clk) begin
        if (store_request) begin
            stage2_store <= store_req;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // L1 bus request, owner picked by the order FIFO head
    always_comb begin
        l1_req.addr = arb_load_sel ? stage2_load.addr : stage2_store.addr;
        l1_req.data = stage2_store.data;
        l1_req.be = stage2_store.be;
        l1_req.rnw = arb_load_sel;
        l1_req.burst_len = (arb_load_sel & ~stage2_load.uncacheable) ? 5'(LINE_W - 1) : 5'd0;
    end

    assign l1_request = load_state[LD_REQ] | store_state[ST_REQ];
    assign load_ack = l1_ack & arb_load_sel;
    assign store_ack = l1_ack & ~arb_load_sel;

    // Free-running one-hot cycler picks the victim way
    always_ff @(posedge clk) begin
        if (rst) begin
            repl_way <= WAYS'(1);
        end else begin
            repl_way <= (repl_way << 1) | (repl_way >> (WAYS - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (load_ack) begin
            fill_way_r <= repl_way;
            fill_idx <= onehot_to_idx(repl_way);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tag and data banks
    dcache_tag_bank #(
        .WAYS(WAYS),
        .LINES(LINES),
        .LINE_W(LINE_W)
    ) u_tag_bank (
        .clk(clk),
        .rst(rst),
        .load_addr(load_req.addr),
        .load_check(load_tag_check),
        .fill_addr(stage2_load.addr),
        .fill_req(load_ack & ~stage2_load.uncacheable),
        .fill_way(repl_way),
        .store_addr(store_req.addr),
        .store_addr_r(stage2_store.addr),
        .store_check(store_request & ~store_req.uncacheable),
        .load_hit(load_hit),
        .load_hit_way(load_hit_way),
        .store_hit_way(store_hit_way)
    );

    assign bank_addr_a = load_state[LD_FILL]
        ? {LINE_IDX_W'(dcache_pkg::line_index(stage2_load.addr, LINES, LINE_W)), word_count}
        : {LINE_IDX_W'(dcache_pkg::line_index(load_req.addr, LINES, LINE_W)),
           WORD_W'(dcache_pkg::word_in_line(load_req.addr, LINE_W))};
    assign bank_addr_b = {LINE_IDX_W'(dcache_pkg::line_index(stage2_store.addr, LINES, LINE_W)),
                          WORD_W'(dcache_pkg::word_in_line(stage2_store.addr, LINE_W))};

    // Fill writes only for cacheable misses
    assign fill_we = fill_way_r & {WAYS{load_state[LD_FILL] & l1_resp.data_valid
                                        & ~stage2_load.uncacheable}};

    for (genvar i = 0; i < WAYS; i++) begin : g_way
        dcache_data_bank #(
            .AW(BANK_AW)
        ) u_data_bank (
            .clk(clk),
            .addr_a(bank_addr_a),
            .en_a(load_tag_check | fill_we[i]),
            .we_a(fill_we[i]),
            .data_in_a(l1_resp.data),
            .data_out_a(bank_out[i]),
            .addr_b(bank_addr_b),
            .en_b(store_hit_way[i]),
            .be_b(stage2_store.be),
            .data_in_b(stage2_store.data)
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Load result
    assign hit_idx = onehot_to_idx(load_hit_way);

    always_ff @(posedge clk) begin
        if (rst) begin
            miss_valid_r <= 1'b0;
        end else begin
            miss_valid_r <= miss_capture;
        end
    end

    // Uncacheable word bypasses the banks
    always_ff @(posedge clk) begin
        if (miss_capture) begin
            uc_word <= l1_resp.data;
        end
    end

    always_comb begin
        if (load_state[LD_CHECK]) begin
            data_out = bank_out[hit_idx];
        end else if (stage2_load.uncacheable) begin
            data_out = uc_word;
        end else begin
            data_out = bank_out[fill_idx];
        end
    end

    assign data_valid = load_hit | miss_valid_r;

endmodule

`default_nettype wire

// File: src/l1_request_order.sv
`timescale 1ns/1ps
`default_nettype none

module l1_request_order (
    input logic clk,
    input logic rst,
    input logic load_push,
    input logic store_push,
    input logic pop,
    output logic arb_load_sel
);

    // One tag per outstanding request, set for a load
    logic [1:0] order_q;
    logic rd_ptr;
    logic wr_ptr;
    logic push;

    assign push = load_push | store_push;

    always_ff @(posedge clk) begin
        if (push) begin
            order_q[wr_ptr] <= load_push;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= 1'b0;
            wr_ptr <= 1'b0;
        end else begin
            rd_ptr <= rd_ptr ^ pop;
            wr_ptr <= wr_ptr ^ push;
        end
    end

    // Oldest request owns the bus
    assign arb_load_sel = order_q[rd_ptr];

endmodule

`default_nettype wire

// File: src/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int WAYS = 2,
    parameter int LINES = 64,
    parameter int LINE_W = 4
) (
    input logic clk,
    input logic rst,
    input logic load_request,
    input dcache_pkg::ls_req_t load_req,
    output logic load_ready,
    input logic store_request,
    input dcache_pkg::ls_req_t store_req,
    output logic store_ready,
    output logic data_valid,
    output logic [dcache_pkg::DATA_W-1:0] data_out,
    output logic l1_request,
    output dcache_pkg::l1_req_t l1_req,
    input logic l1_ack,
    input dcache_pkg::l1_resp_t l1_resp
);

    logic arb_load_sel;
    logic load_hit;

    dcache #(
        .WAYS(WAYS),
        .LINES(LINES),
        .LINE_W(LINE_W)
    ) u_dcache (
        .clk(clk),
        .rst(rst),
        .load_request(load_request),
        .load_req(load_req),
        .store_request(store_request),
        .store_req(store_req),
        .load_ready(load_ready),
        .store_ready(store_ready),
        .load_hit(load_hit),
        .data_valid(data_valid),
        .data_out(data_out),
        .arb_load_sel(arb_load_sel),
        .l1_request(l1_request),
        .l1_req(l1_req),
        .l1_ack(l1_ack),
        .l1_resp(l1_resp)
    );

    // Hits never reach the bus, so they retire from the order FIFO directly
    l1_request_order u_request_order (
        .clk(clk),
        .rst(rst),
        .load_push(load_request),
        .store_push(store_request),
        .pop(l1_ack | load_hit),
        .arb_load_sel(arb_load_sel)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: testbench/l1_memory_model.sv
`timescale 1ns/1ps
`default_nettype none

module l1_memory_model #(
    parameter int SEED = 1,
    parameter int MAX_DELAY = 5
) (
    input logic clk,
    input logic rst,
    input logic l1_request,
    input dcache_pkg::l1_req_t l1_req,
    output logic l1_ack,
    output dcache_pkg::l1_resp_t l1_resp,
    output int read_count,
    output int write_count,
    output logic [4:0] last_burst_len
);

    // Words written over the bus, later entries win
    logic [31:0] wr_addr [$];
    logic [31:0] wr_data [$];

    // Untouched memory reads back a pattern of its own address
    function automatic logic [31:0] init_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ (addr * 32'h0001_0193) ^ 32'h6b3d_a5c1;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [31:0] word;
        word = init_word(addr);
        for (int i = 0; i < wr_addr.size(); i++) begin
            if (wr_addr[i] == addr) begin
                word = wr_data[i];
            end
        end
        return word;
    endfunction

    task automatic write_word(input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] data);
        logic [31:0] word;
        word = read_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                word[8*b +: 8] = data[8*b +: 8];
            end
        end
        wr_addr.push_back(addr);
        wr_data.push_back(word);
    endtask

    // Bus slave, driven on the falling edge
    initial begin
        dcache_pkg::l1_req_t req;
        logic [31:0] base;
        int delay;
        l1_ack = 1'b0;
        l1_resp = '0;
        read_count = 0;
        write_count = 0;
        last_burst_len = '0;
        void'($urandom(SEED));
        forever begin
            @(negedge clk);
            if (!rst && l1_request === 1'b1) begin
                delay = $urandom_range(MAX_DELAY, 0);
                repeat (delay) @(negedge clk);
                req = l1_req;
                l1_ack = 1'b1;
                if (req.rnw) begin
                    read_count++;
                    last_burst_len = req.burst_len;
                end else begin
                    write_count++;
                    write_word({req.addr[31:2], 2'b00}, req.be, req.data);
                end
                @(negedge clk);
                l1_ack = 1'b0;
                if (req.rnw) begin
                    // Align to the burst, then return words in ascending order
                    base = {req.addr[31:2], 2'b00} & ~((32'(req.burst_len) + 1) * 4 - 1);
                    for (int i = 0; i <= req.burst_len; i++) begin
                        l1_resp.data_valid = 1'b1;
                        l1_resp.data = read_word(base + 32'(4 * i));
                        @(negedge clk);
                    end
                    l1_resp = '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    localparam int WAYS = 2;
    localparam int LINES = 64;
    localparam int LINE_W = 4;
    localparam int SEED = 32'h8dd3;
    localparam int READY_TIMEOUT = 200;
    localparam int DATA_TIMEOUT = 200;
    localparam logic [31:0] UC_BASE = 32'hc000_0000;

    localparam logic OP_LOAD = 1'b0;
    localparam logic OP_STORE = 1'b1;

    // What a load should do on the bus
    localparam logic [1:0] EXP_HIT = 2'd0;
    localparam logic [1:0] EXP_MISS = 2'd1;
    localparam logic [1:0] EXP_UC = 2'd2;
    localparam logic [1:0] EXP_ANY = 2'd3;

    typedef struct packed {
        logic op;
        logic [31:0] addr;
        logic [3:0] be;
        logic [31:0] data;
        logic uncacheable;
        logic [1:0] expect_kind;
    } step_t;

    logic clk;
    logic rst;
    logic load_request;
    dcache_pkg::ls_req_t load_req;
    logic load_ready;
    logic store_request;
    dcache_pkg::ls_req_t store_req;
    logic store_ready;
    logic data_valid;
    logic [31:0] data_out;
    logic l1_request;
    dcache_pkg::l1_req_t l1_req;
    logic l1_ack;
    dcache_pkg::l1_resp_t l1_resp;
    int read_count;
    int write_count;
    logic [4:0] last_burst_len;

    step_t steps [$];
    logic [31:0] shadow_addr [$];
    logic [31:0] shadow_data [$];

    tb_clock_gen #(
        .PERIOD_NS(8)
    ) u_clock (
        .clk(clk)
    );

    l1_memory_model #(
        .SEED(SEED),
        .MAX_DELAY(5)
    ) u_memory (
        .clk(clk),
        .rst(rst),
        .l1_request(l1_request),
        .l1_req(l1_req),
        .l1_ack(l1_ack),
        .l1_resp(l1_resp),
        .read_count(read_count),
        .write_count(write_count),
        .last_burst_len(last_burst_len)
    );

    dcache_top #(
        .WAYS(WAYS),
        .LINES(LINES),
        .LINE_W(LINE_W)
    ) u_dut (
        .clk(clk),
        .rst(rst),
        .load_request(load_request),
        .load_req(load_req),
        .load_ready(load_ready),
        .store_request(store_request),
        .store_req(store_req),
        .store_ready(store_ready),
        .data_valid(data_valid),
        .data_out(data_out),
        .l1_request(l1_request),
        .l1_req(l1_req),
        .l1_ack(l1_ack),
        .l1_resp(l1_resp)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Shadow memory, same power-up pattern as the memory model
    function automatic logic [31:0] init_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ (addr * 32'h0001_0193) ^ 32'h6b3d_a5c1;
    endfunction

    function automatic logic [31:0] shadow_read(input logic [31:0] addr);
        logic [31:0] word;
        word = init_word({addr[31:2], 2'b00});
        for (int i = 0; i < shadow_addr.size(); i++) begin
            if (shadow_addr[i] == {addr[31:2], 2'b00}) begin
                word = shadow_data[i];
            end
        end
        return word;
    endfunction

    task automatic shadow_write(input logic [31:0] addr, input logic [3:0] be,
                                input logic [31:0] data);
        logic [31:0] word;
        word = shadow_read(addr);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                word[8*b +: 8] = data[8*b +: 8];
            end
        end
        shadow_addr.push_back({addr[31:2], 2'b00});
        shadow_data.push_back(word);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks and waits
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("ERROR at %0t ns: %s never arrived before the timeout", $time, what);
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout on %s", what);
    endtask

    // Returns on a falling edge where the ready output is high
    task automatic wait_for_ready(input logic op);
        int cycles;
        logic ready;
        cycles = 0;
        ready = 1'b0;
        while (!ready) begin
            @(negedge clk);
            cycles++;
            ready = (op == OP_STORE) ? store_ready : load_ready;
            if (!ready && cycles >= READY_TIMEOUT) begin
                report_timeout(op == OP_STORE ? "store_ready" : "load_ready");
            end
        end
    endtask

    task automatic wait_for_idle();
        int cycles;
        cycles = 0;
        while (!(load_ready && store_ready)) begin
            @(negedge clk);
            cycles++;
            if (!(load_ready && store_ready) && cycles >= READY_TIMEOUT) begin
                report_timeout("load_ready with store_ready");
            end
        end
    endtask

    // Latency counts clock edges after the request cycle
    task automatic wait_for_data(output int latency, output logic [31:0] word);
        logic seen;
        seen = data_valid;
        word = data_out;
        latency = 1;
        while (!seen) begin
            @(negedge clk);
            latency++;
            seen = data_valid;
            word = data_out;
            if (!seen && latency >= DATA_TIMEOUT) begin
                report_timeout("data_valid");
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    task automatic run_load(input step_t s);
        int reads_before;
        int latency;
        logic [31:0] expected;
        logic [31:0] word;
        wait_for_ready(OP_LOAD);
        reads_before = read_count;
        expected = shadow_read(s.addr);
        load_request = 1'b1;
        load_req.addr = s.addr;
        load_req.be = s.be;
        load_req.data = s.data;
        load_req.uncacheable = s.uncacheable;
        @(negedge clk);
        load_request = 1'b0;
        wait_for_data(latency, word);
        check_value("data_out", word, expected);
        wait_for_idle();
        case (s.expect_kind)
            EXP_HIT: begin
                check_value("data_valid latency", latency, 1);
                check_value("l1_request reads", read_count - reads_before, 0);
            end
            EXP_MISS: begin
                check_value("l1_request reads", read_count - reads_before, 1);
                check_value("l1_req.burst_len", last_burst_len, LINE_W - 1);
            end
            EXP_UC: begin
                check_value("l1_request reads", read_count - reads_before, 1);
                check_value("l1_req.burst_len", last_burst_len, 0);
            end
            default: begin
                // Victim way is not predictable, only consistency
                if (read_count == reads_before) begin
                    check_value("data_valid latency", latency, 1);
                end else begin
                    check_value("l1_request reads", read_count - reads_before, 1);
                    check_value("l1_req.burst_len", last_burst_len, LINE_W - 1);
                end
            end
        endcase
    endtask

    task automatic run_store(input step_t s);
        int writes_before;
        wait_for_ready(OP_STORE);
        writes_before = write_count;
        store_request = 1'b1;
        store_req.addr = s.addr;
        store_req.be = s.be;
        store_req.data = s.data;
        store_req.uncacheable = s.uncacheable;
        @(negedge clk);
        store_request = 1'b0;
        shadow_write(s.addr, s.be, s.data);
        // Bus request must be up in the cycle after the strobe
        check_value("l1_request", l1_request, 1);
        check_value("l1_req.rnw", l1_req.rnw, 0);
        check_value("l1_req.addr", l1_req.addr, s.addr);
        wait_for_idle();
        check_value("l1_request writes", write_count - writes_before, 1);
    endtask

    task automatic add_row(input logic op, input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] data, input logic uc, input logic [1:0] kind);
        step_t s;
        s.op = op;
        s.addr = addr;
        s.be = be;
        s.data = data;
        s.uncacheable = uc;
        s.expect_kind = kind;
        steps.push_back(s);
    endtask

    task automatic build_table();
        // Cold miss, then hits anywhere in the line
        add_row(OP_LOAD, 32'h0000_1040, 4'hf, 32'h0, 1'b0, EXP_MISS);
        add_row(OP_LOAD, 32'h0000_104c, 4'hf, 32'h0, 1'b0, EXP_HIT);
        add_row(OP_LOAD, 32'h0000_1044, 4'hf, 32'h0, 1'b0, EXP_HIT);
        // Target word in the middle of the burst
        add_row(OP_LOAD, 32'h0000_2088, 4'hf, 32'h0, 1'b0, EXP_MISS);
        add_row(OP_LOAD, 32'h0000_2080, 4'hf, 32'h0, 1'b0, EXP_HIT);
        add_row(OP_LOAD, 32'h0000_208c, 4'hf, 32'h0, 1'b0, EXP_HIT);
        // Partial store hits merge by byte
        add_row(OP_STORE, 32'h0000_1044, 4'b0011, 32'hdead_beef, 1'b0, EXP_ANY);
        add_row(OP_LOAD, 32'h0000_1044, 4'hf, 32'h0, 1'b0, EXP_HIT);
        add_row(OP_STORE, 32'h0000_1048, 4'b1100, 32'h1234_5678, 1'b0, EXP_ANY);
        add_row(OP_LOAD, 32'h0000_1048, 4'hf, 32'h0, 1'b0, EXP_HIT);
        add_row(OP_LOAD, 32'h0000_1040, 4'hf, 32'h0, 1'b0, EXP_HIT);
        // Store misses reach memory only
        add_row(OP_STORE, 32'h0000_30c4, 4'hf, 32'hcafe_f00d, 1'b0, EXP_ANY);
        add_row(OP_STORE, 32'h0000_30c8, 4'b0100, 32'h00ab_0000, 1'b0, EXP_ANY);
        add_row(OP_LOAD, 32'h0000_30c4, 4'hf, 32'h0, 1'b0, EXP_MISS);
        add_row(OP_LOAD, 32'h0000_30c8, 4'hf, 32'h0, 1'b0, EXP_HIT);
        // Uncacheable region never fills
        add_row(OP_LOAD, UC_BASE + 32'h10, 4'hf, 32'h0, 1'b1, EXP_UC);
        add_row(OP_LOAD, UC_BASE + 32'h10, 4'hf, 32'h0, 1'b1, EXP_UC);
        add_row(OP_STORE, UC_BASE + 32'h14, 4'hf, 32'h5a5a_0f0f, 1'b1, EXP_ANY);
        add_row(OP_LOAD, UC_BASE + 32'h14, 4'hf, 32'h0, 1'b1, EXP_UC);
        // Four lines on index 16 compete for two ways
        add_row(OP_LOAD, 32'h0000_0100, 4'hf, 32'h0, 1'b0, EXP_MISS);
        add_row(OP_LOAD, 32'h0000_0504, 4'hf, 32'h0, 1'b0, EXP_MISS);
        add_row(OP_LOAD, 32'h0000_0908, 4'hf, 32'h0, 1'b0, EXP_MISS);
        add_row(OP_LOAD, 32'h0000_0100, 4'hf, 32'h0, 1'b0, EXP_ANY);
        add_row(OP_LOAD, 32'h0000_050c, 4'hf, 32'h0, 1'b0, EXP_ANY);
        add_row(OP_STORE, 32'h0000_0904, 4'b1001, 32'h7700_0011, 1'b0, EXP_ANY);
        add_row(OP_LOAD, 32'h0000_0904, 4'hf, 32'h0, 1'b0, EXP_ANY);
        add_row(OP_LOAD, 32'h0000_0d00, 4'hf, 32'h0, 1'b0, EXP_MISS);
        add_row(OP_LOAD, 32'h0000_0908, 4'hf, 32'h0, 1'b0, EXP_ANY);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        rst = 1'b1;
        load_request = 1'b0;
        load_req = '0;
        store_request = 1'b0;
        store_req = '0;
        build_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Idle state right after reset
        @(negedge clk);
        check_value("load_ready", load_ready, 1);
        check_value("store_ready", store_ready, 1);
        check_value("l1_request", l1_request, 0);
        check_value("data_valid", data_valid, 0);

        for (int i = 0; i < steps.size(); i++) begin
            if (steps[i].op == OP_STORE) begin
                run_store(steps[i]);
            end else begin
                run_load(steps[i]);
            end
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: dcache_sys.f
common/dcache_pkg.sv
dcache/dcache_data_bank.sv
dcache/dcache_tag_bank.sv
dcache/dcache.sv
src/l1_request_order.sv
src/dcache_top.sv
testbench/tb_clock_gen.sv
testbench/l1_memory_model.sv
testbench/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache_sys

sources:
  - common/dcache_pkg.sv
  - dcache/dcache_data_bank.sv
  - dcache/dcache_tag_bank.sv
  - dcache/dcache.sv
  - src/l1_request_order.sv
  - src/dcache_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/l1_memory_model.sv
      - testbench/dcache_tb.sv
